/* acq_params.svh */
`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

//////////////////////////////
// adc front end
//////////////////////////////

// adc code width
`define ACQ_ADC_BITS 12
// samples packed per burst
`define ACQ_BURST_LEN 4

//////////////////////////////
// storage and header fields
//////////////////////////////

`define ACQ_MEM_AW 10        // 1024 words in the sample memory
`define ACQ_PRETRIG_AW 4     // delay line, up to 15 bursts of pre-trigger
`define ACQ_FILL_BITS 24     // fill number
`define ACQ_TAG_BITS 16      // channel tag
`define ACQ_NBURST_BITS 11   // bursts per fill

`endif

/* acq_pkg.sv */
`default_nettype none
`include "acq_params.svh"

package acq_pkg;

	// one adc sample, 16 bits on the bus
	typedef struct packed {
		logic                          ovr;   // over-range pin at sample time
		logic [16-`ACQ_ADC_BITS-2:0]   pad;   // always zero
		logic [`ACQ_ADC_BITS-1:0]      code;  // raw adc code
	} adc_sample_t;

	// four samples, lane 0 holds the oldest
	typedef struct packed {
		adc_sample_t [`ACQ_BURST_LEN-1:0] lane;
	} adc_burst_t;

	// first word of every fill
	typedef struct packed {
		logic [`ACQ_FILL_BITS-1:0]   fill_num;  // fill counter at trigger
		logic [`ACQ_TAG_BITS-1:0]    tag;       // channel tag
		logic [`ACQ_NBURST_BITS-1:0] nbursts;   // bursts that follow the header
		logic                        ovr_seen;  // over-range in the trigger burst
		logic [62-`ACQ_FILL_BITS-`ACQ_TAG_BITS-`ACQ_NBURST_BITS:0] pad;
	} fill_header_t;

	// one memory word, header or burst depending on its place in the fill
	typedef union packed {
		fill_header_t hdr;
		adc_burst_t   burst;
	} acq_word_u;

	// word address into the sample memory
	typedef logic [`ACQ_MEM_AW-1:0] mem_addr_t;

endpackage

`default_nettype wire

/* adc_acq_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "acq_params.svh"

module adc_acq_top (
	input  wire                          clk125,
	input  wire                          rst,
	input  wire [`ACQ_ADC_BITS-1:0]      adc_data,
	input  wire                          adc_ovr,
	input  wire [`ACQ_TAG_BITS-1:0]      channel_tag,
	input  wire [`ACQ_FILL_BITS-1:0]     initial_fill_num,
	input  wire                          initial_fill_num_wr,
	input  wire [`ACQ_NBURST_BITS-1:0]   async_num_bursts,
	input  wire [`ACQ_PRETRIG_AW-1:0]    async_pre_trig,
	input  wire                          acq_enable,
	input  wire                          acq_trig,
	input  wire acq_pkg::mem_addr_t      rd_start_addr,
	input  wire [`ACQ_MEM_AW:0]          rd_word_cnt,
	input  wire                          rd_start,
	output logic [`ACQ_FILL_BITS-1:0]    fill_num,
	output logic                         acq_done,
	output acq_pkg::mem_addr_t           fill_base_addr,
	output acq_pkg::acq_word_u           rd_data,
	output logic                         rd_valid,
	output logic                         reading_done
);
	import acq_pkg::*;

	adc_burst_t  burst;        // capture -> delay
	logic        burst_stb;
	adc_burst_t  dly_burst;    // delay -> controller
	logic        dly_stb;
	logic        wr_en;        // controller -> memory write port
	mem_addr_t   wr_addr;
	acq_word_u   wr_word;
	logic        mem_rd_en;    // readout <-> memory read port
	mem_addr_t   mem_rd_addr;
	acq_word_u   mem_rd_word;

	adc_sample_capture i_capture (
		.clk125(clk125), .rst(rst), .adc_data(adc_data), .adc_ovr(adc_ovr),
		.burst(burst), .burst_stb(burst_stb)
	);

	pretrig_delay i_pretrig (
		.clk125(clk125), .rst(rst), .burst(burst), .burst_stb(burst_stb),
		.pre_trig(async_pre_trig), .dly_burst(dly_burst), .dly_stb(dly_stb)
	);

	fill_controller i_fill_ctrl (
		.clk125(clk125), .rst(rst), .dly_burst(dly_burst), .dly_stb(dly_stb),
		.acq_enable(acq_enable), .acq_trig(acq_trig), .channel_tag(channel_tag),
		.initial_fill_num(initial_fill_num), .initial_fill_num_wr(initial_fill_num_wr),
		.num_bursts(async_num_bursts), .fill_num(fill_num), .acq_done(acq_done),
		.fill_base_addr(fill_base_addr), .wr_en(wr_en), .wr_addr(wr_addr), .wr_word(wr_word)
	);

	burst_memory i_mem (
		.clk125(clk125), .wr_en(wr_en), .wr_addr(wr_addr), .wr_word(wr_word),
		.rd_en(mem_rd_en), .rd_addr(mem_rd_addr), .rd_word(mem_rd_word)
	);

	readout_engine i_readout (
		.clk125(clk125), .rst(rst), .rd_start(rd_start), .rd_start_addr(rd_start_addr),
		.rd_word_cnt(rd_word_cnt), .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr),
		.mem_rd_word(mem_rd_word), .rd_data(rd_data), .rd_valid(rd_valid),
		.reading_done(reading_done)
	);

endmodule

`default_nettype wire

/* adc_sample_capture.sv */
`timescale 1ns/1ps
`default_nettype none
`include "acq_params.svh"

module adc_sample_capture (
	input  wire                      clk125,
	input  wire                      rst,
	input  wire [`ACQ_ADC_BITS-1:0]  adc_data,
	input  wire                      adc_ovr,
	output acq_pkg::adc_burst_t      burst,
	output logic                     burst_stb
);
	import acq_pkg::*;

	localparam int PW = $clog2(`ACQ_BURST_LEN);

	adc_sample_t          smp;    // incoming sample in bus format
	adc_burst_t           lanes;  // assembly register, shifts every cycle
	logic [PW-1:0]        phase;  // slot of the next sample in the burst
	logic                 full;   // this cycle's sample completes the burst

	assign smp = '{ovr: adc_ovr, pad: '0, code: adc_data};
	assign full = (phase == PW'(`ACQ_BURST_LEN - 1));

	// phase counter and strobe
	always_ff @(posedge clk125) begin
		if (rst) begin
			phase <= '0;
			burst_stb <= 1'b0;
		end else begin
			phase <= phase + 1'b1;  // wraps after the last lane
			burst_stb <= full;      // one cycle after the fourth sample
		end
	end

	// newest sample enters the top lane, oldest drifts down to lane 0
	always_ff @(posedge clk125) begin
		lanes.lane <= {smp, lanes.lane[`ACQ_BURST_LEN-1:1]};
		if (full) begin
			burst.lane <= {smp, lanes.lane[`ACQ_BURST_LEN-1:1]};  // held until next burst
		end
	end

	// bursts are at least four cycles apart
	assert property (@(posedge clk125) disable iff (rst) burst_stb |=> !burst_stb)
		else $error("burst_stb on consecutive cycles");

endmodule

`default_nettype wire

/* burst_memory.sv */
`timescale 1ns/1ps
`default_nettype none
`include "acq_params.svh"

module burst_memory (
	input  wire                       clk125,
	input  wire                       wr_en,
	input  wire acq_pkg::mem_addr_t   wr_addr,
	input  wire acq_pkg::acq_word_u   wr_word,
	input  wire                       rd_en,
	input  wire acq_pkg::mem_addr_t   rd_addr,
	output acq_pkg::acq_word_u        rd_word
);
	import acq_pkg::*;

	localparam int WORDS = 1 << `ACQ_MEM_AW;

	acq_word_u mem [0:WORDS-1];  // block ram in place of the ddr3

	always_ff @(posedge clk125) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_word;
		end
		if (rd_en) begin
			rd_word <= mem[rd_addr];  // one cycle read latency
		end
	end

	assert property (@(posedge clk125) rd_en |-> !$isunknown(rd_addr))
		else $error("read with unknown address");

endmodule

`default_nettype wire

/* fill_controller.sv */
`timescale 1ns/1ps
`default_nettype none
`include "acq_params.svh"

module fill_controller (
	input  wire                          clk125,
	input  wire                          rst,
	input  wire acq_pkg::adc_burst_t     dly_burst,
	input  wire                          dly_stb,
	input  wire                          acq_enable,
	input  wire                          acq_trig,
	input  wire [`ACQ_TAG_BITS-1:0]      channel_tag,
	input  wire [`ACQ_FILL_BITS-1:0]     initial_fill_num,
	input  wire                          initial_fill_num_wr,
	input  wire [`ACQ_NBURST_BITS-1:0]   num_bursts,
	output logic [`ACQ_FILL_BITS-1:0]    fill_num,
	output logic                         acq_done,
	output acq_pkg::mem_addr_t           fill_base_addr,
	output logic                         wr_en,
	output acq_pkg::mem_addr_t           wr_addr,
	output acq_pkg::acq_word_u           wr_word
);
	import acq_pkg::*;

	localparam logic [1:0] S_IDLE   = 2'd0;
	localparam logic [1:0] S_HEADER = 2'd1;  // header on the write port
	localparam logic [1:0] S_BURSTS = 2'd2;

	logic [1:0]                   state;
	mem_addr_t                    base;     // header slot of the next fill
	logic [`ACQ_NBURST_BITS-1:0]  nb_lat;   // burst count taken at acceptance
	logic [`ACQ_NBURST_BITS-1:0]  stored;   // bursts sent to the write port
	logic                         wr_last;  // word on the port closes the fill
	logic                         accept;
	logic                         capture;
	logic                         finish;
	logic                         ovr_now;
	fill_header_t                 hdr;

	assign accept  = (state == S_IDLE) && acq_trig && acq_enable;
	assign capture = (state != S_IDLE) && dly_stb && (stored != nb_lat);
	assign finish  = wr_en && wr_last;

	// The header leaves before any burst is stored, so its over-range flag
	// covers the delayed burst held at acceptance, i.e. the burst just ahead
	// of the first stored one. Over-range inside the stored bursts is still
	// visible per sample in the burst words.
	always_comb begin
		ovr_now = 1'b0;
		for (int i = 0; i < `ACQ_BURST_LEN; i++) begin
			ovr_now = ovr_now | dly_burst.lane[i].ovr;
		end
		hdr = '0;
		hdr.fill_num = fill_num;
		hdr.tag      = channel_tag;
		hdr.nbursts  = num_bursts;
		hdr.ovr_seen = ovr_now;
	end

	//////////////////////////////
	// fill FSM and counters
	//////////////////////////////
	always_ff @(posedge clk125) begin
		if (rst) begin
			state <= S_IDLE;
			wr_en <= 1'b0;
			wr_last <= 1'b0;
			acq_done <= 1'b0;
			fill_num <= '0;
			base <= '0;
			fill_base_addr <= '0;
			nb_lat <= '0;
			stored <= '0;
		end else begin
			wr_en <= accept | capture;
			wr_last <= (accept && num_bursts == '0) || (capture && stored + 1'b1 == nb_lat);
			acq_done <= finish;  // cycle after the last write
			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_HEADER;
						nb_lat <= num_bursts;
						stored <= '0;
					end
					if (initial_fill_num_wr) begin
						fill_num <= initial_fill_num;  // only between fills
					end
				end
				S_HEADER: state <= S_BURSTS;
				default: ;  // S_BURSTS holds until finish
			endcase
			if (capture) begin
				stored <= stored + 1'b1;
			end
			if (finish) begin  // overrides the case, also for zero-burst fills
				state <= S_IDLE;
				fill_num <= fill_num + 1'b1;
				fill_base_addr <= base;
				base <= base + mem_addr_t'(nb_lat) + 1'b1;  // wraps mod 1024
			end
		end
	end

	// write port payload, header first then bursts at base+1, base+2 ...
	always_ff @(posedge clk125) begin
		if (accept) begin
			wr_addr <= base;
			wr_word.hdr <= hdr;
		end else if (capture) begin
			wr_addr <= base + mem_addr_t'(stored) + 1'b1;
			wr_word.burst <= dly_burst;
		end
	end

	assert property (@(posedge clk125) disable iff (rst) wr_en |-> (state != S_IDLE))
		else $error("memory write outside a fill");
	assert property (@(posedge clk125) disable iff (rst) acq_done |=> !acq_done)
		else $error("acq_done longer than one cycle");

endmodule

`default_nettype wire

/* pretrig_delay.sv */
`timescale 1ns/1ps
`default_nettype none
`include "acq_params.svh"

module pretrig_delay (
	input  wire                        clk125,
	input  wire                        rst,
	input  wire acq_pkg::adc_burst_t   burst,
	input  wire                        burst_stb,
	input  wire [`ACQ_PRETRIG_AW-1:0]  pre_trig,
	output acq_pkg::adc_burst_t        dly_burst,
	output logic                       dly_stb
);
	import acq_pkg::*;

	localparam int DEPTH = 1 << `ACQ_PRETRIG_AW;

	adc_burst_t                   ring [0:DEPTH-1];  // last DEPTH bursts
	logic [`ACQ_PRETRIG_AW-1:0]   wr_ptr;            // slot for the next burst
	logic [`ACQ_PRETRIG_AW-1:0]   rd_ptr;

	// wr_ptr-1 holds the previous burst, wr_ptr-k the one k strobes back
	assign rd_ptr = wr_ptr - pre_trig;

	always_ff @(posedge clk125) begin
		if (rst) begin
			wr_ptr <= '0;
			dly_stb <= 1'b0;
		end else begin
			dly_stb <= burst_stb;  // fixed one cycle lag
			if (burst_stb) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	//////////////////////////////
	// ring storage and tap
	//////////////////////////////
	always_ff @(posedge clk125) begin
		if (burst_stb) begin
			ring[wr_ptr] <= burst;
			// depth 0 must bypass, rd_ptr==wr_ptr is the oldest slot
			if (pre_trig == '0) begin
				dly_burst <= burst;
			end else begin
				dly_burst <= ring[rd_ptr];
			end
		end
	end

endmodule

`default_nettype wire

/* readout_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "acq_params.svh"

module readout_engine (
	input  wire                       clk125,
	input  wire                       rst,
	input  wire                       rd_start,
	input  wire acq_pkg::mem_addr_t   rd_start_addr,
	input  wire [`ACQ_MEM_AW:0]       rd_word_cnt,
	output logic                      mem_rd_en,
	output acq_pkg::mem_addr_t        mem_rd_addr,
	input  wire acq_pkg::acq_word_u   mem_rd_word,
	output acq_pkg::acq_word_u        rd_data,
	output logic                      rd_valid,
	output logic                      reading_done
);
	logic                  busy;      // reads still to issue
	logic [`ACQ_MEM_AW:0]  remain;    // words left, including this cycle's
	logic                  last_rd;   // this cycle issues the final read
	logic                  vld_last;  // rd_valid word is the final one

	assign mem_rd_en = busy;  // one read per cycle while busy
	assign last_rd   = (remain == (`ACQ_MEM_AW + 1)'(1));
	assign rd_data   = mem_rd_word;  // memory output lines up with rd_valid

	//////////////////////////////
	// request control
	//////////////////////////////
	always_ff @(posedge clk125) begin
		if (rst) begin
			busy <= 1'b0;
			rd_valid <= 1'b0;
			vld_last <= 1'b0;
			reading_done <= 1'b0;
		end else begin
			rd_valid <= mem_rd_en;
			vld_last <= mem_rd_en && last_rd;
			reading_done <= rd_valid && vld_last;  // after the last valid word
			if (!busy) begin
				if (rd_start) begin
					busy <= (rd_word_cnt != '0);  // zero-length requests issue nothing
				end
			end else if (last_rd) begin
				busy <= 1'b0;
			end
		end
	end

	// address and count, start request is ignored while busy
	always_ff @(posedge clk125) begin
		if (!busy && rd_start) begin
			mem_rd_addr <= rd_start_addr;
			remain <= rd_word_cnt;
		end else if (busy) begin
			mem_rd_addr <= mem_rd_addr + 1'b1;  // wraps mod 1024
			remain <= remain - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator, the verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_adc_acq -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat build.log; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb.f */
+incdir+.
acq_pkg.sv
adc_sample_capture.sv
pretrig_delay.sv
fill_controller.sv
burst_memory.sv
readout_engine.sv
adc_acq_top.sv
tb_adc_acq.sv

/* tb_adc_acq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "acq_params.svh"

module tb_adc_acq;
	import acq_pkg::*;

	localparam int BL = `ACQ_BURST_LEN;
	localparam int ARM_WINDOW = 80;  // longer than any fill used here
	// rough cycles per test: header, bursts, pretrig, numbering, arming, overrange
	localparam int TEST_CYCLES = 120 + 40 + 100 + 200 + ARM_WINDOW + 20 + 160;
	localparam int WATCHDOG_CYCLES = 5 + 40 + TEST_CYCLES + 300;

	logic clk125;
	logic rst;
	logic [`ACQ_ADC_BITS-1:0] adc_data;
	logic adc_ovr;
	logic [`ACQ_TAG_BITS-1:0] channel_tag;
	logic [`ACQ_FILL_BITS-1:0] initial_fill_num;
	logic initial_fill_num_wr;
	logic [`ACQ_NBURST_BITS-1:0] async_num_bursts;
	logic [`ACQ_PRETRIG_AW-1:0] async_pre_trig;
	logic acq_enable;
	logic acq_trig;
	mem_addr_t rd_start_addr;
	logic [`ACQ_MEM_AW:0] rd_word_cnt;
	logic rd_start;
	logic [`ACQ_FILL_BITS-1:0] fill_num;
	logic acq_done;
	mem_addr_t fill_base_addr;
	acq_word_u rd_data;
	logic rd_valid;
	logic reading_done;

	int cyc;                            // index of the edge that takes the next sample
	logic ovr_hist [0:4095];            // adc_ovr per sample index
	logic [15:0] lfsr_state = 16'd95;
	acq_word_u rd_q [$];                // words returned by the last readout
	string cur_test;
	int test_errs;
	int pass_cnt;
	int fail_cnt;
	logic [`ACQ_FILL_BITS-1:0] exp_fill;  // fill number of the next fill
	mem_addr_t exp_next;                  // header slot of the next fill
	mem_addr_t last_base;
	mem_addr_t t1_base;
	int t1_accept;

	adc_acq_top i_adc_acq_top (.*);

	initial begin
		clk125 = 1'b0;
		forever #20 clk125 = ~clk125;
	end

	// ramp source, sample k is taken at edge k after reset
	initial begin
		adc_data = '0;
		cyc = 0;
		@(negedge rst);
		forever begin
			@(posedge clk125);
			ovr_hist[cyc[11:0]] = adc_ovr;
			cyc = cyc + 1;
			#2 adc_data = cyc[`ACQ_ADC_BITS-1:0];
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk125);
		$display("watchdog expired after %0d cycles, a test is stuck", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	//////////////////////////////
	// helpers and reference model
	//////////////////////////////
	task automatic tick();
		@(posedge clk125);
		#2;  // drive and sample point
	endtask

	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};  // x^16+x^14+x^13+x^11+1
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// dly_stb of burst n lands in cycle 4n+5, first one after acceptance is stored
	function automatic int first_sample(input int a, input int p);
		int n;
		n = 0;
		while (BL * n + BL + 1 <= a) n++;
		return BL * (n - p);
	endfunction

	// over-range of the delayed burst held when the header is formed
	function automatic logic hdr_ovr(input int a, input int p);
		int m;
		logic r;
		m = -1;
		r = 1'b0;
		while (BL * (m + 1) + BL < a) m++;  // last burst latched by the delay line
		for (int i = 0; i < BL; i++) r = r | ovr_hist[12'(BL * (m - p) + i)];
		return r;
	endfunction

	task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
		$display("CHECK FAILED %s %s: expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
		test_errs++;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			pass_cnt++;
			$display("[%s] ok", cur_test);
		end else begin
			fail_cnt++;
			$display("[%s] failed with %0d errors", cur_test, test_errs);
		end
	endtask

	// one fill, checks numbering and base chaining at acq_done
	task automatic run_fill(input int nb, input bit retrig, output int a);
		int guard;
		async_num_bursts = `ACQ_NBURST_BITS'(nb);
		acq_trig = 1'b1;
		a = cyc;  // edge that samples the trigger
		tick();
		acq_trig = 1'b0;
		guard = 0;
		while (!acq_done && guard < BL * nb + 24) begin
			acq_trig = retrig && (guard == 3);  // stray trigger inside the fill
			tick();
			guard++;
		end
		acq_trig = 1'b0;
		if (!acq_done) begin
			$display("%s: no acq_done within %0d cycles of the trigger", cur_test, guard);
			test_errs++;
		end else begin
			if (fill_num !== exp_fill + 1'b1)
				mismatch("fill_num", 64'(exp_fill + 1'b1), 64'(fill_num));
			if (fill_base_addr !== exp_next)
				mismatch("fill_base_addr", 64'(exp_next), 64'(fill_base_addr));
		end
		last_base = exp_next;
		exp_next = exp_next + mem_addr_t'(nb + 1);  // wraps mod 1024
		exp_fill = exp_fill + 1'b1;
	endtask

	task automatic read_words(input mem_addr_t addr, input int cnt);
		int guard;
		rd_q.delete();
		rd_start_addr = addr;
		rd_word_cnt = (`ACQ_MEM_AW + 1)'(cnt);
		rd_start = 1'b1;
		tick();
		rd_start = 1'b0;
		guard = 0;
		while (!reading_done && guard < cnt + 8) begin
			if (rd_valid) rd_q.push_back(rd_data);
			tick();
			guard++;
		end
		if (!reading_done) begin
			$display("%s: readout of %0d words at 0x%0h never finished", cur_test, cnt, addr);
			test_errs++;
		end
		if (rd_q.size() != cnt) mismatch("rd_valid count", 64'(cnt), 64'(rd_q.size()));
	endtask

	task automatic check_header(input acq_word_u w, input logic [`ACQ_FILL_BITS-1:0] fnum,
			input int nb, input logic ovr);
		if (w.hdr.fill_num !== fnum) mismatch("hdr fill_num", 64'(fnum), 64'(w.hdr.fill_num));
		if (w.hdr.tag !== channel_tag) mismatch("hdr tag", 64'(channel_tag), 64'(w.hdr.tag));
		if (w.hdr.nbursts !== `ACQ_NBURST_BITS'(nb))
			mismatch("hdr nbursts", 64'(nb), 64'(w.hdr.nbursts));
		if (w.hdr.ovr_seen !== ovr) mismatch("hdr ovr_seen", 64'(ovr), 64'(w.hdr.ovr_seen));
		if (w.hdr.pad !== '0) mismatch("hdr pad", 64'(0), 64'(w.hdr.pad));
	endtask

	// ramp continues across lanes and bursts
	task automatic check_bursts(input int first, input int nb);
		logic [15:0] es;
		for (int j = 0; j < nb && j < rd_q.size(); j++) begin
			for (int i = 0; i < BL; i++) begin
				es = '0;
				es[`ACQ_ADC_BITS-1:0] = `ACQ_ADC_BITS'(first + BL * j + i);
				if (rd_q[j].burst.lane[i] !== es)
					mismatch($sformatf("burst %0d lane %0d", j, i), 64'(es),
						64'(rd_q[j].burst.lane[i]));
			end
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_header();
		logic [`ACQ_FILL_BITS-1:0] load_val;
		int a;
		start_test("header_content");
		load_val = `ACQ_FILL_BITS'(lfsr_take(`ACQ_FILL_BITS));
		channel_tag = `ACQ_TAG_BITS'(lfsr_take(`ACQ_TAG_BITS));
		initial_fill_num = load_val;
		initial_fill_num_wr = 1'b1;
		tick();
		initial_fill_num_wr = 1'b0;
		tick();
		if (fill_num !== load_val) mismatch("loaded fill_num", 64'(load_val), 64'(fill_num));
		exp_fill = load_val;
		run_fill(6, 1'b0, a);
		t1_accept = a;
		t1_base = last_base;
		read_words(last_base, 1);
		if (rd_q.size() == 1) check_header(rd_q[0], load_val, 6, hdr_ovr(a, 0));
		end_test();
	endtask

	task automatic test_bursts_no_pretrig();
		start_test("bursts_depth0");
		read_words(t1_base + 1'b1, 6);
		check_bursts(first_sample(t1_accept, 0), 6);
		end_test();
	endtask

	task automatic test_pretrig();
		int a;
		start_test("pretrig_depth5");
		async_pre_trig = 4'd5;
		repeat (2) tick();
		run_fill(4, 1'b0, a);
		read_words(last_base + 1'b1, 4);
		check_bursts(first_sample(a, 5), 4);  // 20 samples earlier than depth 0
		async_pre_trig = '0;
		tick();
		end_test();
	endtask

	task automatic test_numbering();
		int nbs [0:2];
		int a;
		logic [`ACQ_FILL_BITS-1:0] f0;
		start_test("fill_numbering");
		nbs = '{3, 0, 5};
		for (int k = 0; k < 3; k++) begin
			f0 = exp_fill;
			run_fill(nbs[k], k == 0, a);  // first fill also sees a stray trigger
			read_words(last_base, 1);
			if (rd_q.size() == 1) check_header(rd_q[0], f0, nbs[k], hdr_ovr(a, 0));
			if (k == 0) begin
				read_words(last_base + 1'b1, nbs[k]);
				check_bursts(first_sample(a, 0), nbs[k]);  // data still from the first trigger
			end
			repeat (2) tick();
		end
		end_test();
	endtask

	task automatic test_arming();
		logic [`ACQ_FILL_BITS-1:0] f0;
		logic seen;
		start_test("arming");
		f0 = fill_num;
		seen = 1'b0;
		acq_enable = 1'b0;
		tick();
		acq_trig = 1'b1;
		tick();
		acq_trig = 1'b0;
		repeat (ARM_WINDOW) begin
			tick();
			if (acq_done) seen = 1'b1;
		end
		if (seen) begin
			$display("%s: acq_done pulsed while acq_enable was low", cur_test);
			test_errs++;
		end
		if (fill_num !== f0) mismatch("fill_num", 64'(f0), 64'(fill_num));
		acq_enable = 1'b1;
		tick();
		end_test();
	endtask

	task automatic test_overrange();
		logic [`ACQ_FILL_BITS-1:0] f0;
		logic exp_ovr;
		int a;
		start_test("overrange_readout");
		f0 = exp_fill;
		adc_ovr = 1'b1;  // covers the delayed bursts ahead of the trigger
		repeat (16) tick();
		run_fill(2, 1'b0, a);
		adc_ovr = 1'b0;
		exp_ovr = hdr_ovr(a, 0);
		if (!exp_ovr) begin
			$display("%s: over-range did not reach the burst held at acceptance", cur_test);
			test_errs++;
		end
		read_words(last_base, 3);
		if (rd_q.size() == 3) check_header(rd_q[0], f0, 2, exp_ovr);
		read_words(mem_addr_t'(1010), 30);  // span across the top of memory
		end_test();
	endtask

	initial begin
		rst = 1'b1;
		adc_ovr = 1'b0;
		channel_tag = '0;
		initial_fill_num = '0;
		initial_fill_num_wr = 1'b0;
		async_num_bursts = '0;
		async_pre_trig = '0;
		acq_enable = 1'b0;
		acq_trig = 1'b0;
		rd_start_addr = '0;
		rd_word_cnt = '0;
		rd_start = 1'b0;
		pass_cnt = 0;
		fail_cnt = 0;
		exp_fill = '0;
		exp_next = '0;
		repeat (5) @(posedge clk125);
		#2 rst = 1'b0;
		acq_enable = 1'b1;
		repeat (40) tick();  // fill the delay ring
		test_header();
		test_bursts_no_pretrig();
		test_pretrig();
		test_numbering();
		test_arming();
		test_overrange();
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
